/* source/saturn_params.svh */
`ifndef SATURN_PARAMS_SVH
`define SATURN_PARAMS_SVH

// one nibble of the serial datapath
`define SATURN_NIB_W 4

// A, B, C and D working registers
`define SATURN_WORD_W 64

// program counter, D0 and D1
`define SATURN_ADDR_W 20

// immediate operand of five nibbles
`define SATURN_IMM_W 20

// entries in the return stack
`define SATURN_RSTK_DEPTH 8

`endif

/* source/saturn_pkg.sv */
`default_nettype none

package saturn_pkg;

  // operations understood by the nibble-serial ALU
  typedef enum logic [4:0] {
    OP_ZERO     = 5'd0,
    OP_COPY     = 5'd1,
    OP_TWO_CMPL = 5'd2,
    OP_CLR_MASK = 5'd3,
    OP_SET_BIT  = 5'd4,
    OP_RST_BIT  = 5'd5,
    OP_JMP_REL3 = 5'd6,
    OP_JMP_REL4 = 5'd7,
    OP_JMP_ABS5 = 5'd8
  } alu_op_t;

  // register selects for dest, src1 and src2
  typedef enum logic [4:0] {
    REG_A   = 5'd0,
    REG_B   = 5'd1,
    REG_C   = 5'd2,
    REG_D   = 5'd3,
    REG_D0  = 5'd4,
    REG_D1  = 5'd5,
    REG_P   = 5'd6,
    REG_HST = 5'd7,
    REG_ST  = 5'd8,
    // IMM reads the instruction immediate
    REG_IMM = 5'd9
  } alu_reg_t;

endpackage

`default_nettype wire

/* source/saturn_alu_ctrl_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "saturn_params.svh"

interface alu_ctrl_if
  import saturn_pkg::*;
();

  alu_op_t                  op;
  alu_reg_t                 dest;
  alu_reg_t                 src1;
  alu_reg_t                 src2;
  logic [3:0]               field_start;
  logic [3:0]               field_last;
  logic [`SATURN_IMM_W-1:0] imm;
  logic                     push;
  logic                     pop;
  // ALU status back to the other blocks
  logic                     run;
  logic                     finish;

  modport latch (
    output op, dest, src1, src2, field_start, field_last, imm, push, pop,
    input  run
  );

  modport alu (
    input  op, dest, src1, src2, field_start, field_last, imm,
    output run, finish
  );

  modport pc (
    input op, push, pop, run, finish
  );

endinterface

`default_nettype wire

/* source/saturn_phase_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module saturn_phase_seq (
  input  logic       i_clk,
  input  logic       i_reset,
  output logic [1:0] o_phase,
  output logic       o_en_fetch,
  output logic       o_en_prep,
  output logic       o_en_calc,
  output logic       o_en_save
);

  logic [1:0] phase;
  logic [1:0] phase_next;
  // one-hot with bit n high in phase n
  logic [3:0] en;

  assign phase_next = phase + 2'd1;

  // enables are registered so they stay low through reset
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      phase <= 2'd0;
      en    <= 4'b0000;
    end else begin
      phase <= phase_next;
      en    <= 4'b0001 << phase_next;
    end
  end

  assign o_phase    = phase;
  assign o_en_fetch = en[0];
  assign o_en_prep  = en[1];
  assign o_en_calc  = en[2];
  assign o_en_save  = en[3];

endmodule

`default_nettype wire

/* source/saturn_ins_latch.sv */
`timescale 1ns/10ps
`default_nettype none

`include "saturn_params.svh"

module saturn_ins_latch
  import saturn_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_en_fetch,
  input  logic                     i_en_save,
  input  logic                     i_ins_valid,
  input  alu_op_t                  i_ins_op,
  input  alu_reg_t                 i_ins_dest,
  input  alu_reg_t                 i_ins_src1,
  input  alu_reg_t                 i_ins_src2,
  input  logic [3:0]               i_field_start,
  input  logic [3:0]               i_field_last,
  input  logic [`SATURN_IMM_W-1:0] i_imm,
  input  logic                     i_push,
  input  logic                     i_pop,
  output logic                     o_ins_taken,
  output logic                     o_alu_init,
  alu_ctrl_if.latch                ctrl
);

  // an instruction has been taken but not yet handed to the ALU
  logic pending;
  logic take;

  // only in phase 0 and only while the ALU is idle
  assign take        = i_en_fetch && i_ins_valid && !ctrl.run && !pending;
  assign o_ins_taken = take;

  // init lands on phase 3 of the same round
  assign o_alu_init = i_en_save && pending;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pending <= 1'b0;
    end else if (take) begin
      pending <= 1'b1;
    end else if (o_alu_init) begin
      pending <= 1'b0;
    end
  end

  // fields stay put until the next take and are read directly by the ALU and PC unit
  always_ff @(posedge i_clk) begin
    if (take) begin
      ctrl.op          <= i_ins_op;
      ctrl.dest        <= i_ins_dest;
      ctrl.src1        <= i_ins_src1;
      ctrl.src2        <= i_ins_src2;
      ctrl.field_start <= i_field_start;
      ctrl.field_last  <= i_field_last;
      ctrl.imm         <= i_imm;
      ctrl.push        <= i_push;
      ctrl.pop         <= i_pop;
    end
  end

endmodule

`default_nettype wire

/* source/saturn_alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "saturn_params.svh"

module saturn_alu
  import saturn_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_en_prep,
  input  logic                      i_en_calc,
  input  logic                      i_en_save,
  input  logic                      i_alu_init,
  alu_ctrl_if.alu                   ctrl,
  output logic [`SATURN_ADDR_W-1:0] o_jump_off,
  output logic [`SATURN_ADDR_W-1:0] o_jump_base,
  input  logic [`SATURN_ADDR_W-1:0] i_pc,
  output logic                      o_stall,
  output logic [`SATURN_NIB_W-1:0]  o_reg_p,
  output logic [`SATURN_WORD_W-1:0] o_reg_a,
  output logic [`SATURN_WORD_W-1:0] o_reg_c,
  output logic [15:0]               o_st,
  output logic                      o_carry
);

  // working registers
  logic [`SATURN_WORD_W-1:0] reg_a;
  logic [`SATURN_WORD_W-1:0] reg_b;
  logic [`SATURN_WORD_W-1:0] reg_c;
  logic [`SATURN_WORD_W-1:0] reg_d;
  logic [`SATURN_ADDR_W-1:0] reg_d0;
  logic [`SATURN_ADDR_W-1:0] reg_d1;
  logic [`SATURN_NIB_W-1:0]  reg_p;
  logic [`SATURN_NIB_W-1:0]  reg_hst;
  logic [15:0]               reg_st;
  logic                      carry;

  // field walk
  logic                      run;
  logic [3:0]                f_pos;
  logic [3:0]                f_last;
  logic [3:0]                fld_off;
  logic                      first_nib;
  logic                      last_nib;

  // per-phase pipeline of one nibble
  logic [`SATURN_NIB_W-1:0]  src1_nib;
  logic [`SATURN_NIB_W-1:0]  src2_nib;
  logic [`SATURN_NIB_W-1:0]  p_src1;
  logic [`SATURN_NIB_W-1:0]  p_src2;
  logic                      p_carry;
  logic [`SATURN_NIB_W-1:0]  c_res;
  logic                      c_carry;
  logic                      nonzero;
  logic [`SATURN_NIB_W:0]    neg_sum;

  logic [`SATURN_IMM_W-1:0]  imm_shifted;
  logic [`SATURN_WORD_W-1:0] d0_ext;
  logic [`SATURN_WORD_W-1:0] d1_ext;

  logic [`SATURN_ADDR_W-1:0] jump_off;
  logic [`SATURN_ADDR_W-1:0] jump_next;
  logic [`SATURN_ADDR_W-1:0] jump_base;

  assign fld_off   = f_pos - ctrl.field_start;
  assign first_nib = (f_pos == ctrl.field_start);
  assign last_nib  = (f_pos == f_last);

  // immediate nibbles count from the original field start
  assign imm_shifted = ctrl.imm >> {fld_off, 2'b00};

  // nibbles above the 20-bit registers read as zero
  assign d0_ext = {{(`SATURN_WORD_W - `SATURN_ADDR_W){1'b0}}, reg_d0};
  assign d1_ext = {{(`SATURN_WORD_W - `SATURN_ADDR_W){1'b0}}, reg_d1};

  function automatic logic [`SATURN_NIB_W-1:0] pick_nib(input alu_reg_t sel);
    logic [`SATURN_NIB_W-1:0] nib;
    case (sel)
      REG_A:   nib = reg_a[{f_pos, 2'b00} +: `SATURN_NIB_W];
      REG_B:   nib = reg_b[{f_pos, 2'b00} +: `SATURN_NIB_W];
      REG_C:   nib = reg_c[{f_pos, 2'b00} +: `SATURN_NIB_W];
      REG_D:   nib = reg_d[{f_pos, 2'b00} +: `SATURN_NIB_W];
      REG_D0:  nib = d0_ext[{f_pos, 2'b00} +: `SATURN_NIB_W];
      REG_D1:  nib = d1_ext[{f_pos, 2'b00} +: `SATURN_NIB_W];
      REG_P:   nib = reg_p;
      REG_HST: nib = reg_hst;
      REG_IMM: nib = imm_shifted[`SATURN_NIB_W-1:0];
      default: nib = '0;
    endcase
    return nib;
  endfunction

  always_comb begin
    src1_nib = pick_nib(ctrl.src1);
    src2_nib = pick_nib(ctrl.src2);
  end

  // ~x + 1 on the first nibble, then the carry ripples upward
  assign neg_sum = {1'b0, ~p_src1} + {{`SATURN_NIB_W{1'b0}}, p_carry};

  // jump offset with the current nibble merged in
  always_comb begin
    jump_next = first_nib ? '0 : jump_off;
    if (fld_off < 4'd5) begin
      jump_next[{fld_off[2:0], 2'b00} +: `SATURN_NIB_W] = p_src1;
    end
    // top nibble of a relative offset is the sign
    if (last_nib) begin
      case (ctrl.op)
        OP_JMP_REL3: jump_next = {{8{p_src1[3]}}, p_src1, jump_next[7:0]};
        OP_JMP_REL4: jump_next = {{4{p_src1[3]}}, p_src1, jump_next[11:0]};
        default:     jump_next = jump_next;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_alu_init) begin
      jump_base <= i_pc;
    end
    if (i_en_prep && run) begin
      p_src1  <= src1_nib;
      p_src2  <= src2_nib;
      p_carry <= first_nib ? 1'b1 : c_carry;
    end
    if (i_en_calc && run) begin
      case (ctrl.op)
        OP_ZERO: c_res <= '0;
        OP_COPY, OP_SET_BIT, OP_RST_BIT: c_res <= p_src1;
        OP_TWO_CMPL: begin
          c_res   <= neg_sum[`SATURN_NIB_W-1:0];
          c_carry <= neg_sum[`SATURN_NIB_W];
          nonzero <= (p_src1 != '0) || (!first_nib && nonzero);
        end
        OP_CLR_MASK: c_res <= p_src1 & ~p_src2;
        OP_JMP_REL3, OP_JMP_REL4, OP_JMP_ABS5: jump_off <= jump_next;
        default: c_res <= '0;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      run     <= 1'b0;
      f_pos   <= 4'd0;
      f_last  <= 4'd0;
      reg_a   <= '0;
      reg_b   <= '0;
      reg_c   <= '0;
      reg_d   <= '0;
      reg_d0  <= '0;
      reg_d1  <= '0;
      reg_p   <= '0;
      reg_hst <= '0;
      reg_st  <= '0;
      carry   <= 1'b0;
    end else if (i_alu_init) begin
      run    <= 1'b1;
      f_pos  <= ctrl.field_start;
      f_last <= ctrl.field_last;
    end else if (i_en_save && run) begin
      case (ctrl.op)
        OP_ZERO, OP_COPY, OP_TWO_CMPL, OP_CLR_MASK: begin
          case (ctrl.dest)
            REG_A:   reg_a[{f_pos, 2'b00} +: `SATURN_NIB_W] <= c_res;
            REG_B:   reg_b[{f_pos, 2'b00} +: `SATURN_NIB_W] <= c_res;
            REG_C:   reg_c[{f_pos, 2'b00} +: `SATURN_NIB_W] <= c_res;
            REG_D:   reg_d[{f_pos, 2'b00} +: `SATURN_NIB_W] <= c_res;
            REG_D0: begin
              if (f_pos < 4'd5) reg_d0[{f_pos[2:0], 2'b00} +: `SATURN_NIB_W] <= c_res;
            end
            REG_D1: begin
              if (f_pos < 4'd5) reg_d1[{f_pos[2:0], 2'b00} +: `SATURN_NIB_W] <= c_res;
            end
            REG_ST: begin
              if (f_pos < 4'd4) reg_st[{f_pos[1:0], 2'b00} +: `SATURN_NIB_W] <= c_res;
            end
            REG_P:   reg_p   <= c_res;
            REG_HST: reg_hst <= c_res;
            default: reg_p   <= reg_p;
          endcase
        end
        // the nibble is a bit index into ST
        OP_SET_BIT, OP_RST_BIT: begin
          if (ctrl.dest == REG_ST) reg_st[c_res] <= (ctrl.op == OP_SET_BIT);
        end
        default: reg_st <= reg_st;
      endcase
      f_pos <= f_pos + 4'd1;
      if (last_nib) begin
        run <= 1'b0;
        if (ctrl.op == OP_TWO_CMPL) carry <= nonzero;
      end
    end
  end

  assign ctrl.run    = run;
  assign ctrl.finish = run && i_en_save && last_nib;

  assign o_jump_off  = jump_off;
  assign o_jump_base = jump_base;
  assign o_stall     = run;
  assign o_reg_p     = reg_p;
  assign o_reg_a     = reg_a;
  assign o_reg_c     = reg_c;
  assign o_st        = reg_st;
  assign o_carry     = carry;

endmodule

`default_nettype wire

/* source/saturn_pc_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "saturn_params.svh"

module saturn_pc_unit
  import saturn_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_en_save,
  input  logic                      i_stall,
  input  logic [`SATURN_ADDR_W-1:0] i_jump_off,
  input  logic [`SATURN_ADDR_W-1:0] i_jump_base,
  alu_ctrl_if.pc                    ctrl,
  output logic [`SATURN_ADDR_W-1:0] o_pc
);

  logic [`SATURN_ADDR_W-1:0] pc;
  logic [`SATURN_ADDR_W-1:0] rstk [`SATURN_RSTK_DEPTH];
  logic [2:0]                rstk_ptr;
  logic                      is_jump;
  logic                      finishing;
  logic [`SATURN_ADDR_W-1:0] jump_target;

  assign is_jump     = ctrl.op inside {OP_JMP_REL3, OP_JMP_REL4, OP_JMP_ABS5};
  assign finishing   = i_en_save && ctrl.run && ctrl.finish;
  assign jump_target = (ctrl.op == OP_JMP_ABS5) ? i_jump_off : i_jump_base + i_jump_off;

  // pop wins over a jump target and both win over the increment
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc       <= '1;
      rstk_ptr <= 3'd0;
    end else if (finishing) begin
      if (ctrl.pop) begin
        pc       <= rstk[rstk_ptr - 3'd1];
        rstk_ptr <= rstk_ptr - 3'd1;
      end else begin
        if (is_jump) pc <= jump_target;
        if (ctrl.push) rstk_ptr <= rstk_ptr + 3'd1;
      end
    end else if (i_en_save && !i_stall) begin
      pc <= pc + 1'b1;
    end
  end

  // return address is the PC seen when the instruction was taken
  always_ff @(posedge i_clk) begin
    if (finishing && ctrl.push && !ctrl.pop) begin
      rstk[rstk_ptr] <= i_jump_base;
    end
  end

  assign o_pc = pc;

endmodule

`default_nettype wire

/* source/saturn_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "saturn_params.svh"

module saturn_core
  import saturn_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_ins_valid,
  input  alu_op_t                   i_ins_op,
  input  alu_reg_t                  i_ins_dest,
  input  alu_reg_t                  i_ins_src1,
  input  alu_reg_t                  i_ins_src2,
  input  logic [3:0]                i_field_start,
  input  logic [3:0]                i_field_last,
  input  logic [`SATURN_IMM_W-1:0]  i_imm,
  input  logic                      i_push,
  input  logic                      i_pop,
  output logic                      o_ins_taken,
  output logic                      o_stall,
  output logic [`SATURN_ADDR_W-1:0] o_pc,
  output logic [`SATURN_NIB_W-1:0]  o_reg_p,
  output logic [`SATURN_WORD_W-1:0] o_reg_a,
  output logic [`SATURN_WORD_W-1:0] o_reg_c,
  output logic [15:0]               o_st,
  output logic                      o_carry
);

  logic                      en_fetch;
  logic                      en_prep;
  logic                      en_calc;
  logic                      en_save;
  logic                      alu_init;
  logic [`SATURN_ADDR_W-1:0] jump_off;
  logic [`SATURN_ADDR_W-1:0] jump_base;

  alu_ctrl_if ctrl_if ();

  saturn_phase_seq saturn_phase_seq_inst (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .o_phase    (),
    .o_en_fetch (en_fetch),
    .o_en_prep  (en_prep),
    .o_en_calc  (en_calc),
    .o_en_save  (en_save)
  );

  saturn_ins_latch saturn_ins_latch_inst (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_en_fetch    (en_fetch),
    .i_en_save     (en_save),
    .i_ins_valid   (i_ins_valid),
    .i_ins_op      (i_ins_op),
    .i_ins_dest    (i_ins_dest),
    .i_ins_src1    (i_ins_src1),
    .i_ins_src2    (i_ins_src2),
    .i_field_start (i_field_start),
    .i_field_last  (i_field_last),
    .i_imm         (i_imm),
    .i_push        (i_push),
    .i_pop         (i_pop),
    .o_ins_taken   (o_ins_taken),
    .o_alu_init    (alu_init),
    .ctrl          (ctrl_if.latch)
  );

  saturn_alu saturn_alu_inst (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_en_prep   (en_prep),
    .i_en_calc   (en_calc),
    .i_en_save   (en_save),
    .i_alu_init  (alu_init),
    .ctrl        (ctrl_if.alu),
    .o_jump_off  (jump_off),
    .o_jump_base (jump_base),
    .i_pc        (o_pc),
    .o_stall     (o_stall),
    .o_reg_p     (o_reg_p),
    .o_reg_a     (o_reg_a),
    .o_reg_c     (o_reg_c),
    .o_st        (o_st),
    .o_carry     (o_carry)
  );

  saturn_pc_unit saturn_pc_unit_inst (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_en_save   (en_save),
    .i_stall     (o_stall),
    .i_jump_off  (jump_off),
    .i_jump_base (jump_base),
    .ctrl        (ctrl_if.pc),
    .o_pc        (o_pc)
  );

endmodule

`default_nettype wire

/* verif/saturn_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "saturn_params.svh"

module saturn_core_tb
  import saturn_pkg::*;
();

  localparam int CLK_PERIOD      = 40;
  localparam int SEED_INIT       = 50;
  localparam int LINE_WORDS      = 14;
  localparam int MAX_LINES       = 32;
  localparam int ROUNDS_PER_TEST = 20;
  localparam int WAIT_LIMIT      = ROUNDS_PER_TEST * 4;

  logic                      i_clk;
  logic                      i_reset;
  logic                      i_ins_valid;
  alu_op_t                   i_ins_op;
  alu_reg_t                  i_ins_dest;
  alu_reg_t                  i_ins_src1;
  alu_reg_t                  i_ins_src2;
  logic [3:0]                i_field_start;
  logic [3:0]                i_field_last;
  logic [`SATURN_IMM_W-1:0]  i_imm;
  logic                      i_push;
  logic                      i_pop;
  logic                      o_ins_taken;
  logic                      o_stall;
  logic [`SATURN_ADDR_W-1:0] o_pc;
  logic [`SATURN_NIB_W-1:0]  o_reg_p;
  logic [`SATURN_WORD_W-1:0] o_reg_a;
  logic [`SATURN_WORD_W-1:0] o_reg_c;
  logic [15:0]               o_st;
  logic                      o_carry;

  logic [31:0]               stim_mem [LINE_WORDS*MAX_LINES];
  // PCs of pushing instructions with the newest at the back
  logic [`SATURN_ADDR_W-1:0] return_stack [$];
  int                        seed;
  int                        num_lines;
  int                        num_tests;
  int                        pass_count;
  int                        fail_count;
  int                        err_count;
  int                        line;
  bit                        test_ok;

  saturn_core saturn_core_inst (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_ins_valid   (i_ins_valid),
    .i_ins_op      (i_ins_op),
    .i_ins_dest    (i_ins_dest),
    .i_ins_src1    (i_ins_src1),
    .i_ins_src2    (i_ins_src2),
    .i_field_start (i_field_start),
    .i_field_last  (i_field_last),
    .i_imm         (i_imm),
    .i_push        (i_push),
    .i_pop         (i_pop),
    .o_ins_taken   (o_ins_taken),
    .o_stall       (o_stall),
    .o_pc          (o_pc),
    .o_reg_p       (o_reg_p),
    .o_reg_a       (o_reg_a),
    .o_reg_c       (o_reg_c),
    .o_st          (o_st),
    .o_carry       (o_carry)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // every test gets a fixed budget of rounds
  initial begin
    wait (num_tests > 0);
    #(num_tests * ROUNDS_PER_TEST * 4 * CLK_PERIOD);
    $display("watchdog: the run did not finish within %0d ns",
             num_tests * ROUNDS_PER_TEST * 4 * CLK_PERIOD);
    $display("Test failures found");
    $finish;
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    assert (actual === expected) else begin
      $display("ERR time=%0d ns signal=%s expected=%0h actual=%0h",
               $time, name, expected, actual);
      test_ok = 1'b0;
      err_count++;
    end
  endtask

  task automatic report_test(input int id, input string name);
    if (test_ok) begin
      pass_count++;
      $display("test %0d %s: ok", id, name);
    end else begin
      fail_count++;
      $display("test %0d %s: FAILED", id, name);
    end
  endtask

  task automatic load_stimulus();
    int k;
    for (k = 0; k < LINE_WORDS * MAX_LINES; k++) begin
      stim_mem[k] = '0;
    end
    $readmemh("verif/saturn_core_stimulus.txt", stim_mem);
    // a line with id 0 ends the list
    num_lines = 0;
    while (num_lines < MAX_LINES && stim_mem[num_lines * LINE_WORDS] != 0) begin
      num_lines++;
    end
    if (num_lines == 0) begin
      $display("no stimulus lines could be read from the data file");
    end
  endtask

  task automatic check_reset_state();
    int cycles;
    test_ok = 1'b1;
    @(negedge i_clk);
    check_value("o_ins_taken", {63'd0, o_ins_taken}, 64'd0);
    check_value("o_stall", {63'd0, o_stall}, 64'd0);
    check_value("o_carry", {63'd0, o_carry}, 64'd0);
    check_value("o_reg_p", {60'd0, o_reg_p}, 64'd0);
    check_value("o_pc", {44'd0, o_pc}, {44'd0, 20'hfffff});
    // first idle phase 3 wraps the PC to zero
    cycles = 0;
    while (o_pc == 20'hfffff && cycles < WAIT_LIMIT) begin
      @(negedge i_clk);
      cycles++;
    end
    check_value("o_pc", {44'd0, o_pc}, 64'd0);
    report_test(0, "RESET");
  endtask

  task automatic run_instruction(input int idx);
    logic [31:0]               w [LINE_WORDS];
    alu_op_t                   op;
    logic [63:0]               exp_val;
    logic [`SATURN_ADDR_W-1:0] pc_taken;
    logic [`SATURN_ADDR_W-1:0] exp_pc;
    logic                      took;
    int                        k;
    int                        gap;
    int                        cycles;
    for (k = 0; k < LINE_WORDS; k++) begin
      w[k] = stim_mem[idx * LINE_WORDS + k];
    end
    op      = alu_op_t'(w[1][4:0]);
    exp_val = {w[12], w[13]};
    test_ok = 1'b1;
    gap = $unsigned($random(seed)) % 4;
    repeat (gap) @(posedge i_clk);
    @(posedge i_clk);
    i_ins_valid   <= 1'b1;
    i_ins_op      <= op;
    i_ins_dest    <= alu_reg_t'(w[2][4:0]);
    i_ins_src1    <= alu_reg_t'(w[3][4:0]);
    i_ins_src2    <= alu_reg_t'(w[4][4:0]);
    i_field_start <= w[5][3:0];
    i_field_last  <= w[6][3:0];
    i_imm         <= w[7][`SATURN_IMM_W-1:0];
    i_push        <= w[8][0];
    i_pop         <= w[9][0];
    cycles = 0;
    @(negedge i_clk);
    while (!o_ins_taken && cycles < WAIT_LIMIT) begin
      @(negedge i_clk);
      cycles++;
    end
    took     = o_ins_taken;
    pc_taken = o_pc;
    // the take edge still sees valid high
    @(posedge i_clk);
    i_ins_valid <= 1'b0;
    assert (took) else begin
      $display("test %0d: the instruction was never taken", w[0]);
      test_ok = 1'b0;
    end
    if (took) begin
      cycles = 0;
      @(negedge i_clk);
      while (!o_stall && cycles < WAIT_LIMIT) begin
        @(negedge i_clk);
        cycles++;
      end
      while (o_stall && cycles < WAIT_LIMIT) begin
        @(negedge i_clk);
        cycles++;
      end
      assert (cycles < WAIT_LIMIT) else begin
        $display("test %0d: the ALU did not finish the instruction in time", w[0]);
        test_ok = 1'b0;
      end
      check_value("o_carry", {63'd0, o_carry}, {63'd0, w[11][0]});
      case (w[10])
        1: check_value("o_reg_a", o_reg_a, exp_val);
        2: check_value("o_reg_c", o_reg_c, exp_val);
        3: check_value("o_reg_p", {60'd0, o_reg_p}, exp_val);
        4: check_value("o_st", {48'd0, o_st}, exp_val);
        6: check_value("o_pc", {44'd0, o_pc}, exp_val);
        7: begin
          exp_pc = pc_taken + w[13][`SATURN_ADDR_W-1:0];
          check_value("o_pc", {44'd0, o_pc}, {44'd0, exp_pc});
        end
        8: begin
          assert (return_stack.size() > 0) else begin
            $display("test %0d: pop requested with no earlier push", w[0]);
            test_ok = 1'b0;
          end
          if (return_stack.size() > 0) begin
            exp_pc = return_stack.pop_back();
            check_value("o_pc", {44'd0, o_pc}, {44'd0, exp_pc});
          end
        end
        default: begin
          assert (1'b0) else begin
            $display("test %0d: unknown check selector %0d", w[0], w[10]);
            test_ok = 1'b0;
          end
        end
      endcase
      if (w[8][0]) begin
        return_stack.push_back(pc_taken);
      end
    end
    report_test(w[0], op.name());
  endtask

  initial begin
    seed          = SEED_INIT;
    pass_count    = 0;
    fail_count    = 0;
    err_count     = 0;
    num_tests     = 0;
    i_reset       = 1'b1;
    i_ins_valid   = 1'b0;
    i_ins_op      = OP_ZERO;
    i_ins_dest    = REG_A;
    i_ins_src1    = REG_A;
    i_ins_src2    = REG_A;
    i_field_start = 4'd0;
    i_field_last  = 4'd0;
    i_imm         = '0;
    i_push        = 1'b0;
    i_pop         = 1'b0;
    load_stimulus();
    num_tests = num_lines + 1;
    repeat (4) @(posedge i_clk);
    i_reset <= 1'b0;
    check_reset_state();
    for (line = 0; line < num_lines; line++) begin
      run_instruction(line);
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d value mismatches",
             num_tests, pass_count, fail_count, err_count);
    if (fail_count == 0 && num_lines > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* saturn_core.f */
+incdir+source
source/saturn_pkg.sv
source/saturn_alu_ctrl_if.sv
source/saturn_phase_seq.sv
source/saturn_ins_latch.sv
source/saturn_alu.sv
source/saturn_pc_unit.sv
source/saturn_core.sv
verif/saturn_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 --top-module saturn_core_tb -f saturn_core.f \
  -o saturn_core_sim \
  && ./obj_dir/saturn_core_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log \
  && { echo "simulation FAILED"; exit 1; } \
  || { echo "simulation PASSED"; exit 0; }

/* verif/saturn_core_stimulus.txt */
// id op dest src1 src2 fstart flast imm push pop sel carry exp_hi exp_lo
// sel 1 reg_a, 2 reg_c, 3 reg_p, 4 st, 6 pc, 7 pc at take plus exp_lo, 8 pc of last push
// copy an immediate into A, then into a high field, then zero part of it
1  1 0 9 0 0 4 12345 0 0 1 0 00000000 00012345
2  1 0 9 0 8 b 0beef 0 0 1 0 0000beef 00012345
3  0 0 0 0 a b 00000 0 0 1 0 000000ef 00012345
4  1 6 9 0 0 0 00007 0 0 3 0 00000000 00000007
// two's complement of C, nonzero field then an all-zero field
5  1 2 9 0 0 4 00005 0 0 2 0 00000000 00000005
6  2 2 2 0 0 4 00000 0 0 2 1 00000000 000ffffb
7  2 2 2 0 8 b 00000 0 0 2 0 00000000 000ffffb
// ST bit set and reset, then a masked clear of C
8  4 8 9 0 0 0 00005 0 0 4 0 00000000 00000020
9  4 8 9 0 0 0 0000c 0 0 4 0 00000000 00001020
a  5 8 9 0 0 0 00005 0 0 4 0 00000000 00001000
b  3 2 2 9 0 0 00009 0 0 2 0 00000000 000ffff2
// absolute and relative jumps, positive and negative offsets
c  8 0 9 0 0 4 40000 0 0 6 0 00000000 00040000
d  6 0 9 0 0 2 00123 0 0 7 0 00000000 00000123
e  6 0 9 0 0 2 00f00 0 0 7 0 00000000 000fff00
f  7 0 9 0 0 3 00400 0 0 7 0 00000000 00000400
10 7 0 9 0 0 3 0fff0 0 0 7 0 00000000 000ffff0
// two nested pushes, then two pops
11 8 0 9 0 0 4 20000 1 0 6 0 00000000 00020000
12 6 0 9 0 0 2 00010 1 0 7 0 00000000 00000010
13 8 0 9 0 0 4 30000 0 1 8 0 00000000 00000000
14 8 0 9 0 0 4 30000 0 1 8 0 00000000 00000000
